// ==== Bender.yml ====
package:
  name: posit_mac

sources:
  - hdl/posit_pkg.sv
  - hdl/leading_zero_counter.sv
  - hdl/posit_decoder.sv
  - hdl/posit_multiplier.sv
  - hdl/quire_accumulator.sv
  - hdl/posit_encoder.sv
  - hdl/posit_mac_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/posit_mac_props.sv
      - verif/posit_mac_tb.sv

// ==== compile.f ====
hdl/posit_pkg.sv
hdl/leading_zero_counter.sv
hdl/posit_decoder.sv
hdl/posit_multiplier.sv
hdl/quire_accumulator.sv
hdl/posit_encoder.sv
hdl/posit_mac_top.sv
verif/tb_clock_gen.sv
verif/posit_mac_props.sv
verif/posit_mac_tb.sv

// ==== hdl/leading_zero_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module leading_zero_counter #(
    parameter int IN_W = 8
) (
    input  wire logic [IN_W-1:0]      vec_i,
    output logic [$clog2(IN_W):0]     count_o,
    output logic                      all_zero_o
);

    // walk down from the msb until the first one shows up
    always_comb begin
        count_o    = '0;
        all_zero_o = 1'b1;
        for (int i = IN_W - 1; i >= 0; i--) begin
            if (all_zero_o) begin
                if (vec_i[i]) begin
                    all_zero_o = 1'b0;
                end else begin
                    count_o = count_o + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/posit_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_decoder
    import posit_pkg::*;
(
    input  wire posit_t posit_i,
    output logic        sign_o,
    output logic        zero_o,
    output scale_t      scale_o,
    output sig_t        sig_o
);

    posit_t                      mag;
    logic                        run_one;
    logic [POSIT_W-2:0]          run_vec;
    logic [$clog2(POSIT_W-1):0]  run_len;
    logic                        run_all_zero;
    logic signed [4:0]           regime_k;
    logic [POSIT_W-2:0]          tail;
    logic [ES-1:0]               exp_bits;

    assign sign_o = posit_i[POSIT_W-1];
    assign mag    = sign_o ? -posit_i : posit_i;

    // ----------------------------------------
    // regime
    // ----------------------------------------
    // a run of ones is inverted so the counter only looks for zeros
    assign run_one = mag[POSIT_W-2];
    assign run_vec = run_one ? ~mag[POSIT_W-2:0] : mag[POSIT_W-2:0];

    leading_zero_counter #(
        .IN_W (POSIT_W - 1)
    ) u_run_lzc (
        .vec_i      (run_vec),
        .count_o    (run_len),
        .all_zero_o (run_all_zero)
    );

    assign regime_k = run_one ? $signed({1'b0, run_len}) - 5'sd1
                              : -$signed({1'b0, run_len});

    // ----------------------------------------
    // exponent and fraction
    // ----------------------------------------
    // drop the run and its terminating bit, missing bits shift in as zero
    assign tail     = mag[POSIT_W-2:0] << (run_len + 1'b1);
    assign exp_bits = tail[POSIT_W-2 -: ES];

    // scale = 4k + e
    assign scale_o = {regime_k[4], regime_k, exp_bits};
    assign sig_o   = {1'b1, tail[POSIT_W-2-ES -: FRAC_W]};

    // only code 0 has an empty body with no sign
    assign zero_o = run_all_zero & ~run_one & ~sign_o;

endmodule

`default_nettype wire

// ==== hdl/posit_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_encoder
    import posit_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rstn,
    input  wire logic   sum_vld_i,
    input  wire quire_t sum_i,
    output logic        vld_o,
    output posit_t      acc_o
);

    logic [QUIRE_W-1:0]       sum_mag;
    logic [$clog2(QUIRE_W):0] lz_cnt;
    logic                     sum_zero;
    logic [QUIRE_W-1:0]       norm;

    logic                     st_vld;
    logic                     st_sign;
    logic                     st_zero;
    scale_t                   st_scale;
    logic [FRAC_W:0]          st_frac;
    logic                     st_sticky;

    logic                     k_neg;
    logic [2:0]               rnd_shift;
    logic signed [14:0]       rnd_raw;
    logic signed [14:0]       rnd_str;
    logic                     rnd_up;
    logic [POSIT_W-2:0]       body;
    posit_t                   mag_code;
    posit_t                   code;

    // ----------------------------------------
    // stage 1: magnitude and normalization
    // ----------------------------------------
    assign sum_mag = sum_i[QUIRE_W-1] ? -sum_i : sum_i;

    leading_zero_counter #(
        .IN_W (QUIRE_W)
    ) u_norm_lzc (
        .vec_i      (sum_mag),
        .count_o    (lz_cnt),
        .all_zero_o (sum_zero)
    );

    // leading one lands on the msb, 1.f form
    assign norm = sum_mag << lz_cnt;

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            st_vld <= 1'b0;
        end else begin
            st_vld <= sum_vld_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sum_vld_i) begin
            st_sign   <= sum_i[QUIRE_W-1];
            st_zero   <= sum_zero;
            st_scale  <= scale_t'(QUIRE_W - 1 - QUIRE_FRAC - int'(lz_cnt));
            st_frac   <= norm[QUIRE_W-2 -: FRAC_W+1];
            st_sticky <= |norm[QUIRE_W-3-FRAC_W:0];
        end
    end

    // ----------------------------------------
    // stage 2: regime, exponent, rounding
    // ----------------------------------------
    always_comb begin
        // k = scale >>> 2, e = scale[1:0]
        k_neg     = st_scale < 0;
        rnd_shift = k_neg ? ~st_scale[4:2] : st_scale[4:2];
        // the first bit is replicated by the arithmetic shift into the regime run
        rnd_raw   = {~k_neg, k_neg, st_scale[ES-1:0], st_frac, 7'b0};
        rnd_str   = rnd_raw >>> rnd_shift;
        // nearest, ties to even code
        rnd_up    = rnd_str[7] & (rnd_str[8] | (|rnd_str[6:0]) | st_sticky);
        body      = rnd_str[14:8] + rnd_up;

        if (st_zero) begin
            mag_code = '0;
        end else if (st_scale > MAX_SCALE) begin
            mag_code = MAXPOS;
        end else if (st_scale < -MAX_SCALE) begin
            mag_code = MINPOS;   // never round a nonzero sum to zero
        end else begin
            mag_code = {1'b0, body};
        end

        code = st_sign ? -mag_code : mag_code;
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_o <= 1'b0;
            acc_o <= '0;
        end else begin
            vld_o <= st_vld;
            if (st_vld) begin
                acc_o <= code;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/posit_mac_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_mac_top
    import posit_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rstn,
    input  wire logic   vld_i,
    input  wire posit_t win_i,
    input  wire posit_t din_i,
    output posit_t      acc_o,
    output logic        vld_o
);

    logic      w_sign;
    logic      w_zero;
    scale_t    w_scale;
    sig_t      w_sig;
    logic      d_sign;
    logic      d_zero;
    scale_t    d_scale;
    sig_t      d_sig;

    logic      prod_vld;
    logic      prod_sign;
    logic      prod_zero;
    scale_t    prod_scale;
    prod_sig_t prod_sig;

    logic      sum_vld;
    quire_t    sum;

    // ----------------------------------------
    // decode, multiply
    // ----------------------------------------
    posit_decoder u_dec_w (
        .posit_i (win_i),
        .sign_o  (w_sign),
        .zero_o  (w_zero),
        .scale_o (w_scale),
        .sig_o   (w_sig)
    );

    posit_decoder u_dec_d (
        .posit_i (din_i),
        .sign_o  (d_sign),
        .zero_o  (d_zero),
        .scale_o (d_scale),
        .sig_o   (d_sig)
    );

    posit_multiplier u_mult (
        .clk_i        (clk_i),
        .rstn         (rstn),
        .vld_i        (vld_i),
        .a_sign_i     (w_sign),
        .a_zero_i     (w_zero),
        .a_scale_i    (w_scale),
        .a_sig_i      (w_sig),
        .b_sign_i     (d_sign),
        .b_zero_i     (d_zero),
        .b_scale_i    (d_scale),
        .b_sig_i      (d_sig),
        .prod_vld_o   (prod_vld),
        .prod_sign_o  (prod_sign),
        .prod_zero_o  (prod_zero),
        .prod_scale_o (prod_scale),
        .prod_sig_o   (prod_sig)
    );

    // ----------------------------------------
    // accumulate, round
    // ----------------------------------------
    quire_accumulator u_quire (
        .clk_i        (clk_i),
        .rstn         (rstn),
        .prod_vld_i   (prod_vld),
        .prod_sign_i  (prod_sign),
        .prod_zero_i  (prod_zero),
        .prod_scale_i (prod_scale),
        .prod_sig_i   (prod_sig),
        .sum_vld_o    (sum_vld),
        .sum_o        (sum)
    );

    posit_encoder u_enc (
        .clk_i     (clk_i),
        .rstn      (rstn),
        .sum_vld_i (sum_vld),
        .sum_i     (sum),
        .vld_o     (vld_o),
        .acc_o     (acc_o)
    );

endmodule

`default_nettype wire

// ==== hdl/posit_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_multiplier
    import posit_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   rstn,
    input  wire logic   vld_i,
    input  wire logic   a_sign_i,
    input  wire logic   a_zero_i,
    input  wire scale_t a_scale_i,
    input  wire sig_t   a_sig_i,
    input  wire logic   b_sign_i,
    input  wire logic   b_zero_i,
    input  wire scale_t b_scale_i,
    input  wire sig_t   b_sig_i,
    output logic        prod_vld_o,
    output logic        prod_sign_o,
    output logic        prod_zero_o,
    output scale_t      prod_scale_o,
    output prod_sig_t   prod_sig_o
);

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            prod_vld_o <= 1'b0;
        end else begin
            prod_vld_o <= vld_i;
        end
    end

    // exact product, significand in xx.xxxxxx form
    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            prod_sign_o  <= a_sign_i ^ b_sign_i;
            prod_zero_o  <= a_zero_i | b_zero_i;
            prod_scale_o <= a_scale_i + b_scale_i;
            prod_sig_o   <= a_sig_i * b_sig_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/posit_pkg.sv ====
`default_nettype none

package posit_pkg;

    // ----------------------------------------
    // posit format
    // ----------------------------------------
    localparam int POSIT_W   = 8;
    localparam int ES        = 2;
    localparam int FRAC_W    = 3;
    // maxpos = 2^24, minpos = 2^-24
    localparam int MAX_SCALE = 24;

    // ----------------------------------------
    // dot product and quire
    // ----------------------------------------
    localparam int BLOCK_LEN  = 9;
    // finest product is minpos squared
    localparam int QUIRE_FRAC = 2 * MAX_SCALE;
    localparam int CARRY_W    = 4;
    // sign, carry guard, integer part, fraction part
    localparam int QUIRE_W    = 1 + CARRY_W + 2 * MAX_SCALE + QUIRE_FRAC;

    typedef logic [POSIT_W-1:0]        posit_t;
    typedef logic signed [7:0]         scale_t;
    typedef logic [FRAC_W:0]           sig_t;
    typedef logic [2*FRAC_W+1:0]       prod_sig_t;
    typedef logic signed [QUIRE_W-1:0] quire_t;
    typedef logic [3:0]                pair_cnt_t;

    localparam posit_t MAXPOS = 8'h7f;
    localparam posit_t MINPOS = 8'h01;

endpackage

`default_nettype wire

// ==== hdl/quire_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module quire_accumulator
    import posit_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rstn,
    input  wire logic      prod_vld_i,
    input  wire logic      prod_sign_i,
    input  wire logic      prod_zero_i,
    input  wire scale_t    prod_scale_i,
    input  wire prod_sig_t prod_sig_i,
    output logic           sum_vld_o,
    output quire_t         sum_o
);

    logic [$clog2(QUIRE_W)-1:0]   shift_amt;
    logic [QUIRE_W+2*FRAC_W-1:0]  wide;
    logic [QUIRE_W-1:0]           aligned;
    quire_t                       addend;
    quire_t                       quire;
    pair_cnt_t                    pair_cnt;
    logic                         last_pair;

    // ----------------------------------------
    // alignment
    // ----------------------------------------
    // shift left by scale + QUIRE_FRAC, then drop the 2*FRAC_W product
    // fraction bits, which are zero for anything finer than 2^-48
    assign shift_amt = ($clog2(QUIRE_W))'(int'(prod_scale_i) + QUIRE_FRAC);
    assign wide      = {{(QUIRE_W-2){1'b0}}, prod_sig_i} << shift_amt;
    assign aligned   = wide[QUIRE_W+2*FRAC_W-1 : 2*FRAC_W];

    always_comb begin
        if (prod_zero_i) begin
            addend = '0;
        end else if (prod_sign_i) begin
            addend = -$signed(aligned);
        end else begin
            addend = $signed(aligned);
        end
    end

    assign last_pair = (pair_cnt == pair_cnt_t'(BLOCK_LEN - 1));

    // ----------------------------------------
    // quire and pair counter
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            quire     <= '0;
            pair_cnt  <= '0;
            sum_vld_o <= 1'b0;
        end else begin
            sum_vld_o <= prod_vld_i & last_pair;
            if (prod_vld_i) begin
                if (last_pair) begin
                    // block done, next pair starts from zero
                    quire    <= '0;
                    pair_cnt <= '0;
                end else begin
                    quire    <= quire + addend;
                    pair_cnt <= pair_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (prod_vld_i && last_pair) begin
            sum_o <= quire + addend;
        end
    end

endmodule

`default_nettype wire

// ==== verif/posit_mac_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_mac_props
    import posit_pkg::*;
(
    input wire logic   clk_i,
    input wire logic   rstn,
    input wire logic   vld_i,
    input wire posit_t acc_i
);

    // one result per block, blocks are at least nine pairs apart
    vld_pulse: assert property (@(posedge clk_i) disable iff (!rstn) vld_i |=> !vld_i)
        else $error("vld_o stayed high for more than one cycle");

    vld_in_reset: assert property (@(posedge clk_i) !rstn |-> !vld_i)
        else $error("vld_o high while reset is asserted");

    // NaR is never produced
    no_nar: assert property (@(posedge clk_i) disable iff (!rstn) vld_i |-> acc_i != 8'h80)
        else $error("acc_o carried the NaR code with vld_o high");

endmodule

bind posit_mac_top posit_mac_props u_props (
    .clk_i (clk_i),
    .rstn  (rstn),
    .vld_i (vld_o),
    .acc_i (acc_o)
);

`default_nettype wire

// ==== verif/posit_mac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module posit_mac_tb
    import posit_pkg::*;
();

    localparam int DRIVE_DLY       = 2;
    localparam int RESET_CYCLES    = 5;
    localparam int RAND_BLOCKS     = 20;
    localparam int MAX_GAP         = 3;
    localparam int DIRECTED_BLOCKS = 9;
    // every posit value is a multiple of 2^-24
    localparam int REF_FRAC        = 24;
    localparam int STIM_CYCLES     = (DIRECTED_BLOCKS + 2 * RAND_BLOCKS) * BLOCK_LEN
                                     * (MAX_GAP + 1) + 4 * RESET_CYCLES + 50;
    localparam int TIMEOUT_CYCLES  = 2 * STIM_CYCLES + 100;

    logic                clk_i;
    logic                rstn;
    logic                vld_i;
    posit_t              win_i;
    posit_t              din_i;
    posit_t              acc_o;
    logic                vld_o;

    logic [31:0]         rng_state;
    logic signed [127:0] ref_sum;
    int                  ref_pairs   = 0;
    int                  blocks_sent = 0;
    int                  pulses_seen = 0;
    int                  value_errs  = 0;
    int                  other_errs  = 0;
    int                  cycle_cnt   = 0;
    string               cur_test;
    posit_t              exp_q[$];
    string               name_q[$];

    tb_clock_gen #(
        .PERIOD_NS (40)
    ) u_clk (
        .clk_o (clk_i)
    );

    posit_mac_top DUT (
        .clk_i (clk_i),
        .rstn  (rstn),
        .vld_i (vld_i),
        .win_i (win_i),
        .din_i (din_i),
        .acc_o (acc_o),
        .vld_o (vld_o)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // exact value of an n-bit posit with two exponent bits, REF_FRAC fraction bits
    function automatic longint posit_fixed(input int code, input int n);
        int     mag;
        int     pos;
        int     run;
        int     k;
        int     e;
        int     frac;
        int     fbits;
        int     shift;
        bit     neg;
        bit     rbit;
        longint v;
        neg = ((code >> (n - 1)) & 1) != 0;
        mag = neg ? ((1 << n) - code) & ((1 << n) - 1) : code;
        if (mag == 0) begin
            return 0;
        end
        pos  = n - 2;
        rbit = mag[pos];
        run  = 0;
        while (pos >= 0 && mag[pos] == rbit) begin
            run++;
            pos--;
        end
        k = rbit ? run - 1 : -run;
        // skip the bit that ends the regime
        pos--;
        e = 0;
        repeat (ES) begin
            e = e * 2;
            if (pos >= 0) begin
                e = e + mag[pos];
                pos--;
            end
        end
        frac  = 0;
        fbits = 0;
        while (pos >= 0) begin
            frac = frac * 2 + mag[pos];
            fbits++;
            pos--;
        end
        shift = (1 << ES) * k + e - fbits + REF_FRAC;
        v     = longint'((1 << fbits) + frac);
        v     = (shift >= 0) ? (v << shift) : (v >> (-shift));
        return neg ? -v : v;
    endfunction

    // moves a single posit value to the product scale
    function automatic logic signed [127:0] to_sum_scale(input longint v);
        logic signed [127:0] t;
        t = v;
        return t <<< REF_FRAC;
    endfunction

    function automatic logic signed [127:0] ref_product(input posit_t w, input posit_t d);
        logic signed [127:0] a;
        logic signed [127:0] b;
        a = posit_fixed(int'(w), POSIT_W);
        b = posit_fixed(int'(d), POSIT_W);
        return a * b;
    endfunction

    // nearest code, where the midpoint of two codes is the 9-bit posit {code, 1}
    function automatic posit_t ref_round(input logic signed [127:0] sum);
        logic signed [127:0] m;
        logic signed [127:0] mid;
        int                  c;
        int                  best;
        if (sum == 0) begin
            return 8'h00;
        end
        m    = (sum < 0) ? -sum : sum;
        best = 1;
        for (c = 2; c < 128; c++) begin
            if (m >= to_sum_scale(posit_fixed(c, POSIT_W))) begin
                best = c;
            end
        end
        if (best < 127) begin
            mid = to_sum_scale(posit_fixed((best << 1) | 1, POSIT_W + 1));
            if (m > mid || (m == mid && best % 2 == 1)) begin
                best++;
            end
        end
        return (sum < 0) ? posit_t'(-best) : posit_t'(best);
    endfunction

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_posit(output posit_t p);
        p = 8'h80;
        while (p == 8'h80) begin
            rng_state = lcg_next(rng_state);
            p = rng_state[23:16];
        end
    endtask

    task automatic rand_gap(output int g);
        rng_state = lcg_next(rng_state);
        g = int'(rng_state[24:16]) % (MAX_GAP + 1);
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    task automatic drive_pair(input posit_t w, input posit_t d, input int gap);
        posit_t junk;
        vld_i   = 1'b1;
        win_i   = w;
        din_i   = d;
        ref_sum = ref_sum + ref_product(w, d);
        ref_pairs++;
        if (ref_pairs == BLOCK_LEN) begin
            exp_q.push_back(ref_round(ref_sum));
            name_q.push_back(cur_test);
            blocks_sent++;
            ref_sum   = '0;
            ref_pairs = 0;
        end
        next_cycle();
        vld_i = 1'b0;
        // operands keep changing while vld_i is low
        repeat (gap) begin
            rand_posit(junk);
            win_i = junk;
            rand_posit(junk);
            din_i = junk;
            next_cycle();
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        int     i;
        int     gap;
        posit_t w;
        posit_t d;
        rng_state = 32'hc302bc01;
        ref_sum   = '0;
        rstn      = 1'b0;
        vld_i     = 1'b0;
        win_i     = '0;
        din_i     = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DLY;
        rstn = 1'b1;
        next_cycle();

        cur_test = "zero_block";
        for (i = 0; i < BLOCK_LEN; i++) begin
            rand_posit(w);
            if (i % 2 == 0) begin
                drive_pair(w, 8'h00, 0);
            end else begin
                drive_pair(8'h00, w, 0);
            end
        end

        cur_test = "ones_block";
        repeat (BLOCK_LEN) drive_pair(8'h40, 8'h40, 0);

        cur_test = "mixed_exact";
        for (i = 0; i < BLOCK_LEN; i++) begin
            w = posit_t'(8'h30 + 8 * i);
            d = posit_t'(8'h50 - 4 * i);
            if (i % 2 == 1) begin
                d = -d;
            end
            drive_pair(w, d, 0);
        end

        // four products and their negations, then a zero product
        cur_test = "cancel_block";
        for (i = 0; i < 4; i++) begin
            rand_posit(w);
            rand_posit(d);
            drive_pair(w, d, 0);
            drive_pair(-w, d, 0);
        end
        drive_pair(8'h00, 8'h00, 0);

        cur_test = "minpos_block";
        repeat (BLOCK_LEN) drive_pair(MINPOS, MINPOS, 0);

        cur_test = "sat_pos";
        repeat (BLOCK_LEN) drive_pair(MAXPOS, MAXPOS, 0);

        cur_test = "sat_neg";
        repeat (BLOCK_LEN) drive_pair(8'h81, MAXPOS, 0);

        cur_test = "random_back_to_back";
        repeat (RAND_BLOCKS * BLOCK_LEN) begin
            rand_posit(w);
            rand_posit(d);
            drive_pair(w, d, 0);
        end

        cur_test = "random_gaps";
        repeat (RAND_BLOCKS * BLOCK_LEN) begin
            rand_posit(w);
            rand_posit(d);
            rand_gap(gap);
            drive_pair(w, d, gap);
        end

        // partial block dropped by reset
        wait_drain();
        cur_test = "reset_partial";
        repeat (5) begin
            rand_posit(w);
            rand_posit(d);
            drive_pair(w, d, 0);
        end
        rstn = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        rstn      = 1'b1;
        ref_sum   = '0;
        ref_pairs = 0;

        cur_test = "after_reset";
        repeat (BLOCK_LEN) begin
            rand_posit(w);
            rand_posit(d);
            drive_pair(w, d, 0);
        end
        wait_drain();
        // room for any stray result
        repeat (10) next_cycle();

        assert (pulses_seen == blocks_sent) else begin
            $display("vld_o pulsed %0d times for %0d completed blocks",
                     pulses_seen, blocks_sent);
            other_errs++;
        end
        $display("error count: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // ----------------------------------------
    // result checking
    // ----------------------------------------
    initial begin
        posit_t exp_code;
        string  exp_name;
        forever begin
            @(negedge clk_i);
            if (vld_o) begin
                pulses_seen++;
                assert (exp_q.size() != 0) else begin
                    $display("vld_o pulsed while no result was expected");
                    other_errs++;
                end
                if (exp_q.size() != 0) begin
                    exp_code = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    assert (acc_o == exp_code) else begin
                        $display("CHECK FAILED %s: expected %h, actual %h",
                                 exp_name, exp_code, acc_o);
                        value_errs++;
                    end
                end
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, results still missing", cycle_cnt);
        $display("error count: %0d wrong values, %0d other failures", value_errs, other_errs);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire
